/* hw/com_block.sv */
`timescale 1ns/1ps
`default_nettype none

module com_block (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [7:0] addr,
	input  logic [7:0] in_data,
	input  logic       wr_en,
	input  logic       rd_en,
	output logic [7:0] out_data,
	output logic       interrupt,
	output logic [7:0] leds,
	input  logic [3:0] switches,
	input  logic       key1,
	output logic       uart_tx
);

	logic tx_busy;      // Serializer active, for status and irq

	com_fifo_if fifo_bus ();

	// Register decoder, feeds the FIFO
	com_regs u_regs (
		.clk       (clk),
		.arst_n    (arst_n),
		.addr      (addr),
		.in_data   (in_data),
		.wr_en     (wr_en),
		.rd_en     (rd_en),
		.out_data  (out_data),
		.interrupt (interrupt),
		.leds      (leds),
		.switches  (switches),
		.key1      (key1),
		.tx_busy   (tx_busy),
		.fifo      (fifo_bus.producer)
	);

	com_tx_fifo u_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.fifo   (fifo_bus.fifo_wr_rd)
	);

	// Drains the FIFO onto the serial line
	com_uart_tx u_tx (
		.clk     (clk),
		.arst_n  (arst_n),
		.fifo    (fifo_bus.consumer),
		.tx_busy (tx_busy),
		.uart_tx (uart_tx)
	);

endmodule

`default_nettype wire

/* hw/com_fifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface com_fifo_if;

	logic            push;  // Write strobe
	com_pkg::data_t  wdata; // Byte to store
	logic            full;
	com_pkg::level_t level; // Current fill count
	logic            pop;   // Read strobe, advances head
	com_pkg::data_t  rdata; // Head entry while not empty
	logic            empty;

	modport producer (
		output push,
		output wdata,
		input  full,
		input  empty,
		input  level
	);

	modport fifo_wr_rd (
		input  push,
		input  wdata,
		input  pop,
		output full,
		output empty,
		output level,
		output rdata
	);

	modport consumer (
		output pop,
		input  rdata,
		input  empty
	);

	modport monitor (
		input push,
		input wdata,
		input full,
		input level,
		input pop,
		input rdata,
		input empty
	);

endinterface

`default_nettype wire

/* hw/com_pkg.sv */
`default_nettype none

`include "com_settings.svh"

package com_pkg;

	// Bus data and serial byte
	typedef logic [7:0] data_t;

	// Register address
	typedef logic [7:0] addr_t;

	// FIFO fill count, one bit more than the pointers
	typedef logic [`COM_FIFO_AW:0] level_t;

	// Board switches
	typedef logic [3:0] switch_t;

	// Serializer states
	typedef enum logic [1:0] {
		TX_IDLE,  // Line high, waiting for a byte
		TX_START, // Start bit
		TX_DATA,  // Eight data bits, LSB first
		TX_STOP   // Stop bit
	} tx_state_e;

endpackage

`default_nettype wire

/* hw/com_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "com_settings.svh"

module com_regs (
	input  logic             clk,
	input  logic             arst_n,
	input  com_pkg::addr_t   addr,
	input  com_pkg::data_t   in_data,
	input  logic             wr_en,
	input  logic             rd_en,
	output com_pkg::data_t   out_data,
	output logic             interrupt,
	output com_pkg::data_t   leds,
	input  com_pkg::switch_t switches,
	input  logic             key1,
	input  logic             tx_busy,
	com_fifo_if.producer     fifo
);

	logic             wr_data;      // Write to DATA
	logic             wr_status;
	logic             wr_led;
	logic             wr_irq;
	com_pkg::switch_t sw_meta;
	com_pkg::switch_t sw_sync;
	logic             key_meta;
	logic             key_sync;
	logic             key_prev;     // Delayed copy for edge detect
	logic             key_rise;
	logic [1:0]       irq_en;
	logic [1:0]       irq_en_nxt;
	logic             overflow;
	logic             overflow_nxt;
	logic             key_evt;
	logic             key_evt_nxt;
	logic             tx_done;      // Nothing queued, line idle
	com_pkg::data_t   status;
	com_pkg::data_t   rd_mux;

	assign wr_data   = wr_en && (addr == `COM_ADDR_DATA);
	assign wr_status = wr_en && (addr == `COM_ADDR_STATUS);
	assign wr_led    = wr_en && (addr == `COM_ADDR_LED);
	assign wr_irq    = wr_en && (addr == `COM_ADDR_IRQ_EN);

	// A write into a full FIFO is dropped and flagged
	assign fifo.push  = wr_data && !fifo.full;
	assign fifo.wdata = in_data;

	assign key_rise = key_sync && !key_prev;
	assign tx_done  = fifo.empty && !tx_busy;

	always_comb begin
		status                    = '0;
		status[`COM_ST_EMPTY]     = (fifo.level == '0);
		status[`COM_ST_FULL]      = fifo.full;
		status[`COM_ST_BUSY]      = tx_busy;
		status[`COM_ST_OVERFLOW]  = overflow;
		status[`COM_ST_KEY]       = key_evt;
	end

	always_comb begin
		case (addr)
			`COM_ADDR_STATUS: rd_mux = status;
			`COM_ADDR_LED:    rd_mux = leds;
			`COM_ADDR_SWITCH: rd_mux = {4'b0000, sw_sync};
			`COM_ADDR_IRQ_EN: rd_mux = {6'b000000, irq_en};
			default:          rd_mux = '0;     // DATA and unmapped
		endcase
	end

	// Sticky flags, a new event wins over a clear in the same cycle
	always_comb begin
		irq_en_nxt   = irq_en;
		overflow_nxt = overflow;
		key_evt_nxt  = key_evt;
		if (wr_irq)
			irq_en_nxt = in_data[1:0];
		if (wr_status && in_data[`COM_ST_OVERFLOW])
			overflow_nxt = 1'b0;
		if (wr_status && in_data[`COM_ST_KEY])
			key_evt_nxt = 1'b0;
		if (wr_data && fifo.full)
			overflow_nxt = 1'b1;
		if (key_rise)
			key_evt_nxt = 1'b1;
	end

	// Two-flop synchronizers and the key edge detector
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sw_meta  <= '0;
			sw_sync  <= '0;
			key_meta <= 1'b0;
			key_sync <= 1'b0;
			key_prev <= 1'b0;
		end else begin
			sw_meta  <= switches;
			sw_sync  <= sw_meta;
			key_meta <= key1;
			key_sync <= key_meta;
			key_prev <= key_sync;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			leds      <= '0;
			irq_en    <= '0;
			overflow  <= 1'b0;
			key_evt   <= 1'b0;
			out_data  <= '0;
			interrupt <= 1'b0;
		end else begin
			if (wr_led)
				leds <= in_data;
			irq_en   <= irq_en_nxt;
			overflow <= overflow_nxt;
			key_evt  <= key_evt_nxt;
			if (rd_en)
				out_data <= rd_mux;      // Held until the next read
			// Uses the next enables so a cleared source drops at once
			interrupt <= (irq_en_nxt[0] && tx_done) || (irq_en_nxt[1] && key_evt_nxt);
		end
	end

endmodule

`default_nettype wire

/* hw/com_settings.svh */
`ifndef COM_SETTINGS_SVH
`define COM_SETTINGS_SVH

// Serial bit time in clk cycles, 2 or more
`define COM_CLKS_PER_BIT 8

// Transmit FIFO holds 2**COM_FIFO_AW bytes
`define COM_FIFO_AW 2

// Register map of the byte bus
`define COM_ADDR_DATA   8'h00
`define COM_ADDR_STATUS 8'h01
`define COM_ADDR_LED    8'h02
`define COM_ADDR_SWITCH 8'h03
`define COM_ADDR_IRQ_EN 8'h04

// STATUS bit positions
`define COM_ST_EMPTY    0
`define COM_ST_FULL     1
`define COM_ST_BUSY     2
`define COM_ST_OVERFLOW 3
`define COM_ST_KEY      4

`endif

/* hw/com_tx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "com_settings.svh"

module com_tx_fifo (
	input  logic            clk,
	input  logic            arst_n,
	com_fifo_if.fifo_wr_rd  fifo
);

	localparam int DEPTH = 1 << `COM_FIFO_AW;

	com_pkg::data_t          mem [DEPTH];
	logic [`COM_FIFO_AW-1:0] wr_ptr;
	logic [`COM_FIFO_AW-1:0] rd_ptr;
	com_pkg::level_t         count;
	logic                    do_push;
	logic                    do_pop;

	// Strobes outside the protocol are ignored
	assign do_push = fifo.push && !fifo.full;
	assign do_pop  = fifo.pop && !fifo.empty;

	assign fifo.full  = (count == com_pkg::level_t'(DEPTH));
	assign fifo.empty = (count == '0);
	assign fifo.level = count;
	assign fifo.rdata = mem[rd_ptr];      // Head shown while not empty

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= fifo.wdata;
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;      // Idle or push with pop
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/com_uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "com_settings.svh"

module com_uart_tx (
	input  logic         clk,
	input  logic         arst_n,
	com_fifo_if.consumer fifo,
	output logic         tx_busy,
	output logic         uart_tx
);

	localparam int CNT_W    = $clog2(`COM_CLKS_PER_BIT);
	localparam int BIT_LAST = `COM_CLKS_PER_BIT - 1;

	com_pkg::tx_state_e state;
	logic [CNT_W-1:0]   baud_cnt;    // Cycles into the current bit
	logic [2:0]         bit_idx;     // Data bit being sent
	com_pkg::data_t     shreg;
	logic               bit_end;
	logic               shift;

	assign bit_end = (baud_cnt == CNT_W'(BIT_LAST));
	assign shift   = bit_end && (state == com_pkg::TX_START || state == com_pkg::TX_DATA);

	// Pop straight from idle, the start bit follows on the next cycle
	assign fifo.pop = (state == com_pkg::TX_IDLE) && !fifo.empty;
	assign tx_busy  = fifo.pop || (state != com_pkg::TX_IDLE);

	// Next data bit always sits in shreg[0]
	always_ff @(posedge clk) begin
		if (fifo.pop)
			shreg <= fifo.rdata;
		else if (shift)
			shreg <= shreg >> 1;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= com_pkg::TX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			uart_tx  <= 1'b1;
		end else begin
			if (state == com_pkg::TX_IDLE || bit_end)
				baud_cnt <= '0;
			else
				baud_cnt <= baud_cnt + 1'b1;

			case (state)
				com_pkg::TX_IDLE: begin
					bit_idx <= '0;
					uart_tx <= 1'b1;
					if (fifo.pop) begin
						state   <= com_pkg::TX_START;
						uart_tx <= 1'b0;      // Start bit
					end
				end
				com_pkg::TX_START: begin
					if (bit_end) begin
						state   <= com_pkg::TX_DATA;
						uart_tx <= shreg[0];
					end
				end
				com_pkg::TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							state   <= com_pkg::TX_STOP;
							uart_tx <= 1'b1;  // Stop bit
						end else begin
							bit_idx <= bit_idx + 1'b1;
							uart_tx <= shreg[0];
						end
					end
				end
				com_pkg::TX_STOP: begin
					if (bit_end)
						state <= com_pkg::TX_IDLE;
				end
				default: begin
					state   <= com_pkg::TX_IDLE;
					uart_tx <= 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/com_pkg.sv
hw/com_fifo_if.sv
hw/com_regs.sv
hw/com_tx_fifo.sv
hw/com_uart_tx.sv
hw/com_block.sv
verif/com_block_chk.sv
verif/com_block_tb.sv

/* verif/com_block_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "com_settings.svh"

module com_block_chk (
	input logic            clk,
	input logic            arst_n,
	input logic            uart_tx,
	input logic            tx_busy,
	input logic            interrupt,
	input logic [1:0]      irq_en,
	input com_pkg::level_t level,
	input logic            pop,
	input logic            empty
);

	localparam int DEPTH = 1 << `COM_FIFO_AW;

	int fail_count = 0;   // Failed assertions so far

	// Idle line stays at mark level
	line_idle: assert property (@(posedge clk) disable iff (!arst_n) !tx_busy |-> uart_tx)
		else begin
			$error("uart_tx low while the transmitter is idle");
			fail_count++;
		end

	level_max: assert property (@(posedge clk) disable iff (!arst_n)
		level <= com_pkg::level_t'(DEPTH))
		else begin
			$error("FIFO level above its depth");
			fail_count++;
		end

	irq_masked: assert property (@(posedge clk) disable iff (!arst_n)
		(irq_en == 2'b00) |-> !interrupt)
		else begin
			$error("interrupt high with all sources disabled");
			fail_count++;
		end

	pop_guard: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
		else begin
			$error("FIFO popped while empty");
			fail_count++;
		end

endmodule

bind com_block com_block_chk u_chk (
	.clk       (clk),
	.arst_n    (arst_n),
	.uart_tx   (uart_tx),
	.tx_busy   (tx_busy),
	.interrupt (interrupt),
	.irq_en    (u_regs.irq_en),
	.level     (fifo_bus.level),
	.pop       (fifo_bus.pop),
	.empty     (fifo_bus.empty)
);

`default_nettype wire

/* verif/com_block_stim.txt */
# Columns: test name, opcode, address (hex), data or expected value (hex)
# W write, R read and compare, T serial byte, S switches, K key pulse, I interrupt after drain
rst_led      R 02 00
rst_irq_en   R 04 00
rst_status   R 01 01
led_wr       W 02 a5
led_rd       R 02 a5
sw_set       S 00 0a
sw_rd        R 03 0a
tx_wr0       W 00 55
tx_wr1       W 00 c3
tx_wr2       W 00 0f
tx_byte0     T 00 55
tx_byte1     T 00 c3
tx_byte2     T 00 0f
tx_drain     I 00 00
ovf_hold     W 00 11
ovf_wr0      W 00 21
ovf_wr1      W 00 22
ovf_wr2      W 00 23
ovf_wr3      W 00 24
ovf_wr4      W 00 25
ovf_status   R 01 0e
ovf_clear    W 01 08
ovf_cleared  R 01 06
ovf_byte_h   T 00 11
ovf_byte0    T 00 21
ovf_byte1    T 00 22
ovf_byte2    T 00 23
ovf_byte3    T 00 24
ovf_drain    I 00 00
key_pulse    K 00 00
key_status   R 01 11
key_irq_en   W 04 02
key_irq      I 00 01
key_clear    W 01 10
key_irq_off  I 00 00
done_irq_en  W 04 01
done_wr      W 00 5a
done_byte    T 00 5a
done_irq     I 00 01

/* verif/com_block_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "com_settings.svh"

module com_block_tb;

	localparam int WAIT_LIMIT = 2000;  // Cycles allowed for one serial byte
	localparam int POLL_LIMIT = 500;   // STATUS reads allowed for a drain

	logic       clk;
	logic       arst_n;
	logic [7:0] addr;
	logic [7:0] in_data;
	logic       wr_en;
	logic       rd_en;
	logic [7:0] out_data;
	logic       interrupt;
	logic [7:0] leds;
	logic [3:0] switches;
	logic       key1;
	logic       uart_tx;
	logic [7:0] rx_q [$];              // Bytes seen on the serial line

	com_block UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.addr      (addr),
		.in_data   (in_data),
		.wr_en     (wr_en),
		.rd_en     (rd_en),
		.out_data  (out_data),
		.interrupt (interrupt),
		.leds      (leds),
		.switches  (switches),
		.key1      (key1),
		.uart_tx   (uart_tx)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
		@(posedge clk);
		addr    <= a;
		in_data <= d;
		wr_en   <= 1'b1;
		@(posedge clk);
		wr_en   <= 1'b0;
	endtask

	// Result is taken on the falling edge after out_data updates
	task automatic bus_read(input logic [7:0] a, output logic [7:0] d);
		@(posedge clk);
		addr  <= a;
		rd_en <= 1'b1;
		@(posedge clk);
		rd_en <= 1'b0;
		@(negedge clk);
		d = out_data;
	endtask

	// Flags an interrupt seen while a poll still showed the path busy
	task automatic wait_drained(input string name, output logic irq_early);
		logic [7:0] st;
		int         polls;
		st        = 8'h00;
		polls     = 0;
		irq_early = 1'b0;
		while (!(st[`COM_ST_EMPTY] && !st[`COM_ST_BUSY]) && polls < POLL_LIMIT) begin
			bus_read(`COM_ADDR_STATUS, st);
			if (!(st[`COM_ST_EMPTY] && !st[`COM_ST_BUSY]) && interrupt !== 1'b0)
				irq_early = 1'b1;
			polls++;
		end
		assert (st[`COM_ST_EMPTY] && !st[`COM_ST_BUSY]) else begin
			$display("Timeout in %s: transmit path did not drain", name);
			abort_run();
		end
	endtask

	// 8N1 frame entered half a cycle into the start bit
	task automatic receive_byte(output logic [7:0] b);
		repeat (`COM_CLKS_PER_BIT / 2) @(negedge clk);
		assert (uart_tx === 1'b0) else begin
			$display("Start bit on uart_tx shorter than half a bit");
			abort_run();
		end
		for (int i = 0; i < 8; i++) begin
			repeat (`COM_CLKS_PER_BIT) @(negedge clk);
			b[i] = uart_tx;                  // LSB first
		end
		repeat (`COM_CLKS_PER_BIT) @(negedge clk);
		assert (uart_tx === 1'b1) else begin
			$display("Framing error: stop bit on uart_tx is low");
			abort_run();
		end
	endtask

	initial begin : serial_monitor
		logic       prev_line;
		logic [7:0] rx_byte;
		prev_line = 1'b1;
		forever begin
			@(negedge clk);
			if (prev_line === 1'b1 && uart_tx === 1'b0) begin
				receive_byte(rx_byte);
				rx_q.push_back(rx_byte);
				prev_line = 1'b1;            // Left in the middle of the stop bit
			end else begin
				prev_line = uart_tx;
			end
		end
	end

	initial begin : assertion_watch
		forever begin
			@(negedge clk);
			if (UUT.u_chk.fail_count != 0) begin
				$display("Bound assertion failed inside the DUT");
				abort_run();
			end
		end
	end

	task automatic run_op(input string name, input string op, input logic [7:0] a,
		input logic [7:0] d);
		logic [7:0] got;
		int         waited;
		logic       early;
		case (op)
			"W": begin
				bus_write(a, d);
				if (a == `COM_ADDR_LED) begin
					@(negedge clk);
					assert (leds == d) else begin
						$display("MISMATCH %s: expected %h, actual %h", name, d, leds);
						abort_run();
					end
				end
			end
			"R": begin
				bus_read(a, got);
				assert (got == d) else begin
					$display("MISMATCH %s: expected %h, actual %h", name, d, got);
					abort_run();
				end
			end
			"T": begin
				waited = 0;
				while (rx_q.size() == 0 && waited < WAIT_LIMIT) begin
					@(negedge clk);
					waited++;
				end
				assert (rx_q.size() > 0) else begin
					$display("Timeout in %s: no byte arrived on uart_tx", name);
					abort_run();
				end
				got = rx_q.pop_front();
				assert (got == d) else begin
					$display("MISMATCH %s: expected %h, actual %h", name, d, got);
					abort_run();
				end
			end
			"S": begin
				@(posedge clk);
				switches <= d[3:0];
				repeat (3) @(posedge clk);   // Through both synchronizer flops
			end
			"K": begin
				@(posedge clk);
				key1 <= 1'b1;
				repeat (4) @(posedge clk);
				key1 <= 1'b0;
				repeat (4) @(posedge clk);
			end
			"I": begin
				wait_drained(name, early);
				// A raised level must not come before the drain
				assert (!(d[0] && early)) else begin
					$display("Interrupt in %s was high before the transmit path drained",
						name);
					abort_run();
				end
				assert (interrupt === d[0]) else begin
					$display("MISMATCH %s: expected %b, actual %b", name, d[0], interrupt);
					abort_run();
				end
			end
			default: begin
				$display("Unknown opcode %s in test %s", op, name);
				abort_run();
			end
		endcase
	endtask

	initial begin : main
		int         fd;
		int         rc;
		int         n;
		int         ops;
		string      line;
		string      name;
		string      op;
		logic [7:0] a;
		logic [7:0] d;
		arst_n   = 1'b0;
		addr     = 8'h00;
		in_data  = 8'h00;
		wr_en    = 1'b0;
		rd_en    = 1'b0;
		switches = 4'h0;
		key1     = 1'b0;
		ops      = 0;
		void'($urandom(32'h89bc_3f44));
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		assert (uart_tx === 1'b1) else begin
			$display("MISMATCH rst_line: expected 1, actual %b", uart_tx);
			abort_run();
		end
		fd = $fopen("verif/com_block_stim.txt", "r");
		assert (fd != 0) else begin
			$display("Stimulus file verif/com_block_stim.txt could not be opened");
			abort_run();
		end
		while (!$feof(fd)) begin
			rc = $fgets(line, fd);
			n  = 0;
			if (rc > 0 && line.substr(0, 0) != "#")
				n = $sscanf(line, "%s %s %h %h", name, op, a, d);
			if (n == 4) begin
				run_op(name, op, a, d);
				ops++;
				repeat ($urandom % 4) @(posedge clk);  // Idle gap between operations
			end
		end
		$fclose(fd);
		assert (ops > 0) else begin
			$display("Stimulus file holds no operations");
			abort_run();
		end
		if (rx_q.size() != 0)
			$display("%0d unexpected bytes left from uart_tx", rx_q.size());
		if (UUT.u_chk.fail_count != 0)
			$display("Bound assertion failed inside the DUT");
		if (rx_q.size() == 0 && UUT.u_chk.fail_count == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire
